// ==== list.f ====
source/neuro_cfg_pkg.sv
source/packet_fifo.sv
source/config_decoder.sv
source/config_memory.sv
source/status_memory.sv
source/neuro_cfg_top.sv
verification/neuro_cfg_checker.sv
verification/neuro_cfg_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, the log decides the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module neuro_cfg_tb -f list.f \
    -o sim_neuro_cfg > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_neuro_cfg > sim.log 2>&1
status=$?
cat sim.log
grep -q "Checks failed" sim.log && { echo "FAIL"; exit 1; }
[ "$status" -eq 0 ] && grep -q "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== verification/neuro_cfg_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

module neuro_cfg_tb
    import neuro_cfg_pkg::*;
();

    localparam int MAX_CYCLES = 5000;   // a few times the longest run

    logic             clk;
    logic             reset_n;
    logic             en_config;
    logic             push;
    logic             full;
    logic             busy;
    cfg_packet_t      pkt;
    stat_write_t      ctrl_wr;
    mem_read_t        cfg_rd;
    mem_read_t        stat_rd;
    logic [CFG_W-1:0] cfg_rd_data;
    logic [DSIZE-1:0] stat_rd_data;

    // shadow copies of both memories
    logic [CFG_W-1:0] cfg_ref [8][64];
    logic [CFG_W-1:0] count_ref;
    logic [DSIZE-1:0] stat_ref [5][64];
    logic [DSIZE-1:0] weight_ref [4096];
    mem_read_t        rd_list [$];
    int               errors = 0;
    int               checks = 0;
    int               cycles = 0;

    neuro_cfg_top #(
        .FIFO_DEPTH_LOG2 (3)
    ) i_neuro_cfg_top (
        .clk_i          (clk),
        .reset_n_i      (reset_n),
        .en_config_i    (en_config),
        .push_i         (push),
        .pkt_i          (pkt),
        .ctrl_wr_i      (ctrl_wr),
        .cfg_rd_i       (cfg_rd),
        .stat_rd_i      (stat_rd),
        .full_o         (full),
        .busy_o         (busy),
        .cfg_rd_data_o  (cfg_rd_data),
        .stat_rd_data_o (stat_rd_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: DUT still busy after %0d cycles", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic check_cfg(input string name, input logic [CFG_W-1:0] act,
                             input logic [CFG_W-1:0] exp);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("** Error: %s = 0x%08h, expected 0x%08h", name, act, exp);
        end
    endtask

    task automatic check_stat(input string name, input logic [DSIZE-1:0] act,
                              input logic [DSIZE-1:0] exp);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("** Error: %s = 0x%04h, expected 0x%04h", name, act, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, act, exp);
        end
    endtask

    function automatic logic [CFG_W-1:0] expect_cfg(input mem_read_t r);
        if (r.op == OP_NEURON_AXON_COUNT)
            return count_ref;   // one count for every neuron
        return cfg_ref[int'(r.op)][r.neuron];
    endfunction

    function automatic logic [DSIZE-1:0] expect_stat(input mem_read_t r);
        if (r.op == OP_WEIGHT)
            return weight_ref[{r.neuron, r.axon}];
        return stat_ref[int'(r.op) - 10][r.neuron];
    endfunction

    task automatic apply_ref(input cfg_packet_t p);
        if (p.op <= OP_LEARN_MODE_WEIGHT)
            cfg_ref[int'(p.op)][p.neuron] = p.data;
        else if (p.op == OP_NEURON_AXON_COUNT)
            count_ref = p.data;
        else if (p.op == OP_WEIGHT)
            weight_ref[{p.neuron, p.axon}] = p.data[DSIZE-1:0];
        else if (p.op != OP_RESERVED)
            stat_ref[int'(p.op) - 10][p.neuron] = p.data[DSIZE-1:0];   // low half only
    endtask

    function automatic cfg_packet_t make_packet(input int op, input int neuron,
                                                input int axon);
        cfg_packet_t p;
        p.op     = cfg_op_e'(op);
        p.neuron = neuron[NEURON_W-1:0];
        p.axon   = axon[AXON_W-1:0];
        p.data   = $urandom();
        return p;
    endfunction

    function automatic mem_read_t read_req(input cfg_packet_t p);
        mem_read_t r;
        r.en     = 1'b1;
        r.op     = p.op;
        r.neuron = p.neuron;
        r.axon   = p.axon;
        return r;
    endfunction

    // every task below returns on a falling edge
    task automatic set_mode(input logic on);
        @(posedge clk);
        en_config <= on;
        @(negedge clk);
    endtask

    task automatic push_packet(input cfg_packet_t p, input bit allow_drop);
        while (full && !allow_drop)
            @(negedge clk);
        @(posedge clk);
        push <= 1'b1;
        pkt  <= p;
        @(posedge clk);
        push <= 1'b0;
        @(negedge clk);
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (busy)
            @(negedge clk);
    endtask

    task automatic ctrl_write(input stat_write_t w);
        @(posedge clk);
        ctrl_wr <= w;
        @(posedge clk);
        ctrl_wr.en <= 1'b0;   // write lands on this edge
        @(negedge clk);
    endtask

    task automatic read_back(input mem_read_t req);
        @(posedge clk);
        if (req.op <= OP_NEURON_AXON_COUNT)
            cfg_rd <= req;
        else
            stat_rd <= req;
        @(posedge clk);
        cfg_rd.en  <= 1'b0;
        stat_rd.en <= 1'b0;
        @(negedge clk);
        if (req.op <= OP_NEURON_AXON_COUNT)
            check_cfg("cfg_rd_data_o", cfg_rd_data, expect_cfg(req));
        else
            check_stat("stat_rd_data_o", stat_rd_data, expect_stat(req));
    endtask

    task automatic send_and_log(input cfg_packet_t p);
        push_packet(p, 1'b0);
        apply_ref(p);
        rd_list.push_back(read_req(p));
    endtask

    task automatic test_cfg_writes();
        cfg_packet_t p;
        mem_read_t   r;
        rd_list.delete();
        set_mode(1'b1);
        for (int op = 0; op <= 8; op++)
            for (int k = 0; k < 3; k++)
            begin
                p = make_packet(op, $urandom_range(63), 0);
                send_and_log(p);
            end
        wait_idle();
        set_mode(1'b0);
        foreach (rd_list[i])
            read_back(rd_list[i]);
        r = read_req(p);   // last packet is the count
        r.neuron = ~r.neuron;
        read_back(r);
    endtask

    task automatic test_stat_writes();
        cfg_packet_t p;
        rd_list.delete();
        set_mode(1'b1);
        for (int op = 10; op <= 15; op++)
            for (int k = 0; k < 3; k++)
            begin
                p = make_packet(op, $urandom_range(63), $urandom_range(63));
                send_and_log(p);
            end
        for (int a = 20; a <= 21; a++)
        begin
            p = make_packet(15, 5, a);
            p.data[0] = a[0];   // neighbour weights always differ
            send_and_log(p);
        end
        wait_idle();
        set_mode(1'b0);
        foreach (rd_list[i])
            read_back(rd_list[i]);
    endtask

    task automatic test_reserved_and_mux();
        cfg_packet_t p;
        stat_write_t w;
        mem_read_t   r;
        set_mode(1'b1);
        p = make_packet(9, rd_list[0].neuron, rd_list[0].axon);
        push_packet(p, 1'b0);
        wait_idle();
        set_mode(1'b0);
        for (int op = 0; op <= 15; op++)
            if (op != 9)
            begin
                r    = read_req(p);
                r.op = cfg_op_e'(op);
                read_back(r);
            end
        w.en     = 1'b1;
        w.sel    = SEL_POTENTIAL;
        w.neuron = NEURON_W'($urandom_range(63));
        w.axon   = '0;
        w.data   = DSIZE'($urandom());
        ctrl_write(w);
        stat_ref[int'(SEL_POTENTIAL)][w.neuron] = w.data;
        r = '{en: 1'b1, op: OP_POTENTIAL, neuron: w.neuron, axon: '0};
        read_back(r);
        set_mode(1'b1);
        w.data = ~w.data;   // dropped, decoder owns the port
        ctrl_write(w);
        set_mode(1'b0);
        read_back(r);
    endtask

    task automatic test_queueing();
        cfg_packet_t first;
        cfg_packet_t other;
        cfg_packet_t last;
        logic [NEURON_W-1:0] n;
        n     = NEURON_W'($urandom_range(63));
        first = make_packet(12, n, 0);
        other = make_packet(5, n, 0);
        last  = first;
        last.data = ~first.data;
        push_packet(first, 1'b0);
        push_packet(other, 1'b0);
        push_packet(last, 1'b0);
        repeat (4) @(negedge clk);
        check_flag("busy_o", busy, 1'b1);
        read_back(read_req(first));   // nothing applied yet
        set_mode(1'b1);
        wait_idle();
        set_mode(1'b0);
        apply_ref(first);
        apply_ref(other);
        apply_ref(last);
        read_back(read_req(last));
        read_back(read_req(other));
    endtask

    task automatic test_overflow();
        cfg_packet_t p [9];
        for (int i = 0; i < 9; i++)
        begin
            p[i] = make_packet(14, i, 0);
            push_packet(p[i], 1'b1);
            check_flag("full_o", full, i >= 7);
        end
        set_mode(1'b1);
        wait_idle();
        set_mode(1'b0);
        for (int i = 0; i < 8; i++)
            apply_ref(p[i]);   // ninth was dropped
        for (int i = 0; i < 9; i++)
            read_back(read_req(p[i]));
    endtask

    initial
    begin
        void'($urandom(32'h31d0d77a));
        reset_n   = 1'b0;
        en_config = 1'b0;
        push      = 1'b0;
        pkt       = '0;
        ctrl_wr   = '0;
        cfg_rd    = '0;
        stat_rd   = '0;
        count_ref = '0;
        foreach (cfg_ref[b, n])
            cfg_ref[b][n] = '0;
        foreach (stat_ref[b, n])
            stat_ref[b][n] = '0;
        foreach (weight_ref[s])
            weight_ref[s] = '0;
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        test_cfg_writes();
        test_stat_writes();
        test_reserved_and_mux();
        test_queueing();
        test_overflow();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/neuro_cfg_checker.sv ====
`default_nettype none
`timescale 1ns/100ps

module neuro_cfg_checker
(
    input wire logic clk_i,
    input wire logic reset_n_i,
    input wire logic full_i,
    input wire logic empty_i,
    input wire logic pop_i,
    input wire logic en_config_i,
    input wire logic cfg_wr_en_i,
    input wire logic stat_pkt_en_i,
    input wire logic stat_wr_en_i
);

    full_and_empty_a: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        !(full_i && empty_i))
        else $error("FIFO flags full and empty together");

    pop_when_empty_a: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        pop_i |-> !empty_i)
        else $error("pop issued on an empty FIFO");

    // packets only land in config mode
    write_in_run_mode_a: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        !en_config_i |-> !(cfg_wr_en_i || stat_pkt_en_i))
        else $error("packet write while configuration mode is off");

    one_write_a: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        !(cfg_wr_en_i && stat_wr_en_i))
        else $error("configuration and status writes in the same cycle");

endmodule

bind packet_fifo neuro_cfg_checker i_fifo_checker (
    .clk_i         (clk_i),
    .reset_n_i     (reset_n_i),
    .full_i        (full_o),
    .empty_i       (empty_o),
    .pop_i         (pop_i),
    .en_config_i   (1'b1),
    .cfg_wr_en_i   (1'b0),
    .stat_pkt_en_i (1'b0),
    .stat_wr_en_i  (1'b0)
);

bind config_decoder neuro_cfg_checker i_decoder_checker (
    .clk_i         (clk_i),
    .reset_n_i     (reset_n_i),
    .full_i        (1'b0),
    .empty_i       (fifo_empty_i),
    .pop_i         (fifo_pop_o),
    .en_config_i   (en_config_i),
    .cfg_wr_en_i   (cfg_wr_o.en),
    .stat_pkt_en_i (pkt_stat.en),
    .stat_wr_en_i  (stat_wr_o.en)
);

`default_nettype wire

// ==== source/neuro_cfg_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module neuro_cfg_top
    import neuro_cfg_pkg::*;
#(
    parameter int FIFO_DEPTH_LOG2 = 3
)
(
    input  wire logic        clk_i,
    input  wire logic        reset_n_i,
    input  wire logic        en_config_i,
    input  wire logic        push_i,
    input  wire cfg_packet_t pkt_i,
    input  wire stat_write_t ctrl_wr_i,
    input  wire mem_read_t   cfg_rd_i,
    input  wire mem_read_t   stat_rd_i,
    output logic             full_o,
    output logic             busy_o,
    output logic [CFG_W-1:0] cfg_rd_data_o,
    output logic [DSIZE-1:0] stat_rd_data_o
);

    cfg_packet_t fifo_pkt;
    logic        fifo_pop;
    logic        fifo_empty;
    cfg_write_t  cfg_wr;
    stat_write_t stat_wr;   // already muxed between packet and controller

    packet_fifo #(
        .DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) i_packet_fifo (
        .clk_i     (clk_i),
        .reset_n_i (reset_n_i),
        .push_i    (push_i),
        .pkt_i     (pkt_i),
        .pop_i     (fifo_pop),
        .pkt_o     (fifo_pkt),
        .full_o    (full_o),
        .empty_o   (fifo_empty)
    );

    config_decoder i_config_decoder (
        .clk_i        (clk_i),
        .reset_n_i    (reset_n_i),
        .en_config_i  (en_config_i),
        .fifo_pkt_i   (fifo_pkt),
        .fifo_empty_i (fifo_empty),
        .ctrl_wr_i    (ctrl_wr_i),
        .fifo_pop_o   (fifo_pop),
        .cfg_wr_o     (cfg_wr),
        .stat_wr_o    (stat_wr),
        .busy_o       (busy_o)
    );

    config_memory i_config_memory (
        .clk_i     (clk_i),
        .reset_n_i (reset_n_i),
        .wr_i      (cfg_wr),
        .rd_i      (cfg_rd_i),
        .rd_data_o (cfg_rd_data_o)
    );

    status_memory i_status_memory (
        .clk_i     (clk_i),
        .reset_n_i (reset_n_i),
        .wr_i      (stat_wr),
        .rd_i      (stat_rd_i),
        .rd_data_o (stat_rd_data_o)
    );

endmodule

`default_nettype wire

// ==== source/status_memory.sv ====
`default_nettype none
`timescale 1ns/100ps

module status_memory
    import neuro_cfg_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        reset_n_i,
    input  wire stat_write_t wr_i,
    input  wire mem_read_t   rd_i,
    output logic [DSIZE-1:0] rd_data_o
);

    localparam int NEURONS  = 1 << NEURON_W;
    localparam int SYNAPSES = 1 << SYN_W;
    localparam int NBANKS   = 5;   // per-neuron banks, weight kept apart

    logic [DSIZE-1:0] stat_bank [NBANKS][NEURONS];
    logic [DSIZE-1:0] weight    [SYNAPSES];

    // single write port
    always_ff @(posedge clk_i or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            for (int b = 0; b < NBANKS; b++)
            begin
                for (int n = 0; n < NEURONS; n++)
                    stat_bank[b][n] <= '0;
            end
            for (int s = 0; s < SYNAPSES; s++)
                weight[s] <= '0;
        end
        else if (wr_i.en)
        begin
            if (wr_i.sel == SEL_WEIGHT)
                weight[{wr_i.neuron, wr_i.axon}] <= wr_i.data;
            else if (wr_i.sel < SEL_WEIGHT)
                stat_bank[wr_i.sel][wr_i.neuron] <= wr_i.data;
        end
    end

    // registered read, opcodes 10 to 15 map onto the banks
    always_ff @(posedge clk_i or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            rd_data_o <= '0;
        end
        else if (rd_i.en)
        begin
            case (rd_i.op)
                OP_BIAS:
                    rd_data_o <= stat_bank[SEL_BIAS][rd_i.neuron];
                OP_POTENTIAL:
                    rd_data_o <= stat_bank[SEL_POTENTIAL][rd_i.neuron];
                OP_THRESHOLD:
                    rd_data_o <= stat_bank[SEL_THRESHOLD][rd_i.neuron];
                OP_POST_HISTORY:
                    rd_data_o <= stat_bank[SEL_POST_HISTORY][rd_i.neuron];
                OP_PRE_HISTORY:
                    rd_data_o <= stat_bank[SEL_PRE_HISTORY][rd_i.neuron];
                OP_WEIGHT:
                    rd_data_o <= weight[{rd_i.neuron, rd_i.axon}];
                default:
                    rd_data_o <= '0;   // config opcode or reserved
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/config_memory.sv ====
`default_nettype none
`timescale 1ns/100ps

module config_memory
    import neuro_cfg_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       reset_n_i,
    input  wire cfg_write_t wr_i,
    input  wire mem_read_t  rd_i,
    output logic [CFG_W-1:0] rd_data_o
);

    localparam int NEURONS = 1 << NEURON_W;
    localparam int BANKS   = 8;   // opcodes 0 to 7

    logic [CFG_W-1:0] cfg_bank [BANKS][NEURONS];
    logic [CFG_W-1:0] count_q;    // global neuron/axon count

    // write side
    always_ff @(posedge clk_i or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            for (int b = 0; b < BANKS; b++)
            begin
                for (int n = 0; n < NEURONS; n++)
                    cfg_bank[b][n] <= '0;
            end
            count_q <= '0;
        end
        else if (wr_i.en)
        begin
            if (wr_i.op == OP_NEURON_AXON_COUNT)
                count_q <= wr_i.data;
            else if (wr_i.op <= OP_LEARN_MODE_WEIGHT)
                cfg_bank[wr_i.op[2:0]][wr_i.neuron] <= wr_i.data;
        end
    end

    // registered read, held until the next request
    always_ff @(posedge clk_i or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            rd_data_o <= '0;
        end
        else if (rd_i.en)
        begin
            if (rd_i.op == OP_NEURON_AXON_COUNT)
                rd_data_o <= count_q;   // shared by all neurons
            else if (rd_i.op <= OP_LEARN_MODE_WEIGHT)
                rd_data_o <= cfg_bank[rd_i.op[2:0]][rd_i.neuron];
            else
                rd_data_o <= '0;        // status opcode
        end
    end

endmodule

`default_nettype wire

// ==== source/config_decoder.sv ====
`default_nettype none
`timescale 1ns/100ps

module config_decoder
    import neuro_cfg_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        reset_n_i,
    input  wire logic        en_config_i,
    input  wire cfg_packet_t fifo_pkt_i,
    input  wire logic        fifo_empty_i,
    input  wire stat_write_t ctrl_wr_i,
    output logic             fifo_pop_o,
    output cfg_write_t       cfg_wr_o,
    output stat_write_t      stat_wr_o,
    output logic             busy_o
);

    logic        pop_q;     // registered pop pulse
    logic        pend_q;    // popped packet waiting to be written
    cfg_packet_t pkt_q;
    logic        is_cfg;
    logic        is_stat;
    stat_sel_e   sel;
    stat_write_t pkt_stat;

    // pop at most every other cycle so empty has settled before the next pop
    always_ff @(posedge clk_i or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            pop_q  <= 1'b0;
            pend_q <= 1'b0;
        end
        else
        begin
            pop_q  <= en_config_i && !fifo_empty_i && !pop_q;
            // a packet caught by a mode change waits for config mode
            pend_q <= pop_q || (pend_q && !en_config_i);
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (pop_q)
            pkt_q <= fifo_pkt_i;
    end

    assign fifo_pop_o = pop_q;
    assign busy_o     = !fifo_empty_i || pend_q;

    // opcode decode
    always_comb
    begin
        is_cfg  = 1'b0;
        is_stat = 1'b1;
        sel     = SEL_BIAS;
        case (pkt_q.op)
            OP_LTP_LTD_WINDOW,
            OP_LEARN_RATE,
            OP_LEARN_MODE_BIAS,
            OP_NEURON_TYPE,
            OP_MASK_REST,
            OP_AER,
            OP_FIXED_THRESHOLD,
            OP_LEARN_MODE_WEIGHT,
            OP_NEURON_AXON_COUNT:
            begin
                is_cfg  = 1'b1;
                is_stat = 1'b0;
            end
            OP_BIAS:         sel = SEL_BIAS;
            OP_POTENTIAL:    sel = SEL_POTENTIAL;
            OP_THRESHOLD:    sel = SEL_THRESHOLD;
            OP_POST_HISTORY: sel = SEL_POST_HISTORY;
            OP_PRE_HISTORY:  sel = SEL_PRE_HISTORY;
            OP_WEIGHT:       sel = SEL_WEIGHT;
            default:         is_stat = 1'b0;   // reserved, discarded
        endcase
    end

    // configuration write, count register ignores the neuron field downstream
    assign cfg_wr_o.en     = pend_q && en_config_i && is_cfg;
    assign cfg_wr_o.op     = pkt_q.op;
    assign cfg_wr_o.neuron = pkt_q.neuron;
    assign cfg_wr_o.data   = pkt_q.data;

    assign pkt_stat.en     = pend_q && en_config_i && is_stat;
    assign pkt_stat.sel    = sel;
    assign pkt_stat.neuron = pkt_q.neuron;
    assign pkt_stat.axon   = pkt_q.axon;
    assign pkt_stat.data   = pkt_q.data[DSIZE-1:0];  // low half only

    // status port owner follows the mode
    assign stat_wr_o = en_config_i ? pkt_stat : ctrl_wr_i;

endmodule

`default_nettype wire

// ==== source/packet_fifo.sv ====
`default_nettype none
`timescale 1ns/100ps

module packet_fifo
    import neuro_cfg_pkg::*;
#(
    parameter int DEPTH_LOG2 = 3
)
(
    input  wire logic        clk_i,
    input  wire logic        reset_n_i,
    input  wire logic        push_i,
    input  wire cfg_packet_t pkt_i,
    input  wire logic        pop_i,
    output cfg_packet_t      pkt_o,
    output logic             full_o,
    output logic             empty_o
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    cfg_packet_t           mem [DEPTH];
    logic [DEPTH_LOG2:0]   wr_ptr;  // extra msb tells full from empty
    logic [DEPTH_LOG2:0]   rd_ptr;
    logic                  do_push;
    logic                  do_pop;

    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]) &&
                     (wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]);

    assign do_push = push_i && !full_o;   // drop when full
    assign do_pop  = pop_i && !empty_o;

    // head shown without a register stage
    assign pkt_o = mem[rd_ptr[DEPTH_LOG2-1:0]];

    always_ff @(posedge clk_i or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // storage
    always_ff @(posedge clk_i)
    begin
        if (do_push)
            mem[wr_ptr[DEPTH_LOG2-1:0]] <= pkt_i;
    end

endmodule

`default_nettype wire

// ==== source/neuro_cfg_pkg.sv ====
`default_nettype none

package neuro_cfg_pkg;

    // id and word widths
    localparam int NEURON_W = 6;                // 64 neurons
    localparam int AXON_W   = 6;
    localparam int SYN_W    = NEURON_W + AXON_W; // 4096 synapses
    localparam int DSIZE    = 16;               // status word
    localparam int CFG_W    = 2 * DSIZE;        // configuration word

    // packet opcodes
    typedef enum logic [3:0] {
        OP_LTP_LTD_WINDOW    = 4'd0,
        OP_LEARN_RATE        = 4'd1,
        OP_LEARN_MODE_BIAS   = 4'd2,
        OP_NEURON_TYPE       = 4'd3,
        OP_MASK_REST         = 4'd4,
        OP_AER               = 4'd5,
        OP_FIXED_THRESHOLD   = 4'd6,
        OP_LEARN_MODE_WEIGHT = 4'd7,
        OP_NEURON_AXON_COUNT = 4'd8,
        OP_RESERVED          = 4'd9,   // popped and dropped
        OP_BIAS              = 4'd10,
        OP_POTENTIAL         = 4'd11,
        OP_THRESHOLD         = 4'd12,
        OP_POST_HISTORY      = 4'd13,
        OP_PRE_HISTORY       = 4'd14,
        OP_WEIGHT            = 4'd15
    } cfg_op_e;

    // status bank select
    typedef enum logic [2:0] {
        SEL_BIAS         = 3'd0,
        SEL_POTENTIAL    = 3'd1,
        SEL_THRESHOLD    = 3'd2,
        SEL_POST_HISTORY = 3'd3,
        SEL_PRE_HISTORY  = 3'd4,
        SEL_WEIGHT       = 3'd5
    } stat_sel_e;

    typedef struct packed {
        cfg_op_e               op;
        logic [NEURON_W-1:0]   neuron;
        logic [AXON_W-1:0]     axon;
        logic [CFG_W-1:0]      data;
    } cfg_packet_t;

    typedef struct packed {
        logic                  en;
        cfg_op_e               op;
        logic [NEURON_W-1:0]   neuron;
        logic [CFG_W-1:0]      data;
    } cfg_write_t;

    // axon only matters for SEL_WEIGHT
    typedef struct packed {
        logic                  en;
        stat_sel_e             sel;
        logic [NEURON_W-1:0]   neuron;
        logic [AXON_W-1:0]     axon;
        logic [DSIZE-1:0]      data;
    } stat_write_t;

    typedef struct packed {
        logic                  en;
        cfg_op_e               op;
        logic [NEURON_W-1:0]   neuron;
        logic [AXON_W-1:0]     axon;
    } mem_read_t;

endpackage

`default_nettype wire
